// File: rtl/cache_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, types and address helpers shared by the cache RTL
// and the testbench; import with cache_pkg::*
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cache_pkg;

  localparam int ADDR_W      = 10;
  localparam int OFF_W       = 6;
  localparam int IDX_W       = 2;
  localparam int TAG_W       = ADDR_W - OFF_W - IDX_W;
  localparam int WORD_W      = 64;
  localparam int LINE_W      = 512;
  localparam int SEL_W       = 3;
  // byte offset inside a word is dropped
  localparam int SEL_LSB     = 3;
  localparam int CACHE_LINES = 1 << IDX_W;
  localparam int LINE_ADDR_W = ADDR_W - OFF_W;
  localparam int MEM_LINES   = 16;
  localparam int MEM_LAT     = 3;

  typedef logic [ADDR_W-1:0]               addr_t;
  typedef logic [WORD_W-1:0]               word_t;
  typedef logic [LINE_W-1:0]               line_t;
  typedef logic [TAG_W-1:0]                tag_t;
  typedef logic [IDX_W-1:0]                index_t;
  typedef logic [SEL_W-1:0]                word_sel_t;
  typedef logic [LINE_ADDR_W-1:0]          line_addr_t;
  typedef logic [$clog2(MEM_LAT+1)-1:0]    lat_cnt_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t wdata;
  } cpu_req_t;

  // read commands carry a line address, writes a word address
  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t wdata;
  } mem_cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    FILL_WAIT,
    WRITE_WAIT,
    RESPOND
  } ctrl_state_t;

  function automatic tag_t addr_tag(addr_t a);
    return a[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic index_t addr_idx(addr_t a);
    return a[OFF_W +: IDX_W];
  endfunction

  function automatic word_sel_t addr_sel(addr_t a);
    return a[SEL_LSB +: SEL_W];
  endfunction

  function automatic line_addr_t addr_line(addr_t a);
    return a[ADDR_W-1:OFF_W];
  endfunction

  // pick one 64-bit lane out of a line
  function automatic word_t get_word(line_t line, word_sel_t sel);
    return line[sel*WORD_W +: WORD_W];
  endfunction

endpackage

// File: rtl/cache_store.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// direct-mapped tag, valid and data arrays; combinational
// lookup, whole-line fill and single-word update
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_store import cache_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  index_t    lookup_idx,
  output tag_t      lookup_tag,
  output logic      lookup_valid,
  output line_t     lookup_line,
  input  logic      fill_en,
  input  index_t    fill_idx,
  input  tag_t      fill_tag,
  input  line_t     fill_line,
  input  logic      upd_en,
  input  index_t    upd_idx,
  input  word_sel_t upd_sel,
  input  word_t     upd_word
);

  line_t                  lines [CACHE_LINES];
  tag_t                   tags  [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid;

  assign lookup_tag   = tags[lookup_idx];
  assign lookup_valid = valid[lookup_idx];
  assign lookup_line  = lines[lookup_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (fill_en) begin
      valid[fill_idx] <= 1'b1;
    end
  end

  // fill and update never happen in the same cycle
  always_ff @(posedge clk) begin
    if (fill_en) begin
      lines[fill_idx] <= fill_line;
      tags[fill_idx]  <= fill_tag;
    end else if (upd_en) begin
      lines[upd_idx][upd_sel*WORD_W +: WORD_W] <= upd_word;
    end
  end

endmodule

// File: rtl/cache_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache controller FSM: hit check, read-miss line fill and
// write-through with update on hit, one access at a time
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      enable,
  input  cpu_req_t  req,
  output word_t     rdata,
  output logic      done,
  output logic      hit,
  // store lookup
  output index_t    lookup_idx,
  input  tag_t      lookup_tag,
  input  logic      lookup_valid,
  input  line_t     lookup_line,
  // store fill and update
  output logic      fill_en,
  output index_t    fill_idx,
  output tag_t      fill_tag,
  output line_t     fill_line,
  output logic      upd_en,
  output index_t    upd_idx,
  output word_sel_t upd_sel,
  output word_t     upd_word,
  // backing memory
  output logic      mem_req,
  output mem_cmd_t  mem_cmd,
  input  line_t     mem_rdata,
  input  logic      mem_valid
);

  ctrl_state_t state;
  ctrl_state_t next_state;
  cpu_req_t    req_q;
  tag_t        cur_tag;
  index_t      cur_idx;
  word_sel_t   cur_sel;
  logic        lookup_hit;
  logic        wr_hit_q;

  assign cur_tag    = addr_tag(req_q.addr);
  assign cur_idx    = addr_idx(req_q.addr);
  assign cur_sel    = addr_sel(req_q.addr);
  assign lookup_idx = cur_idx;
  assign lookup_hit = lookup_valid && (lookup_tag == cur_tag);

  assign fill_idx  = cur_idx;
  assign fill_tag  = cur_tag;
  assign fill_line = mem_rdata;
  assign upd_idx   = cur_idx;
  assign upd_sel   = cur_sel;
  assign upd_word  = req_q.wdata;

  // reads fetch the whole line, so the offset is cleared
  always_comb begin
    mem_cmd.write = req_q.write;
    mem_cmd.wdata = req_q.wdata;
    if (req_q.write) begin
      mem_cmd.addr = req_q.addr;
    end else begin
      mem_cmd.addr = {addr_line(req_q.addr), {OFF_W{1'b0}}};
    end
  end

  always_comb begin
    next_state = state;
    mem_req    = 1'b0;
    fill_en    = 1'b0;
    upd_en     = 1'b0;
    case (state)
      IDLE: begin
        if (enable) begin
          next_state = LOOKUP;
        end
      end
      LOOKUP: begin
        if (req_q.write) begin
          // write-through, cached copy patched only when resident
          mem_req    = 1'b1;
          upd_en     = lookup_hit;
          next_state = WRITE_WAIT;
        end else if (lookup_hit) begin
          next_state = RESPOND;
        end else begin
          mem_req    = 1'b1;
          next_state = FILL_WAIT;
        end
      end
      FILL_WAIT: begin
        if (mem_valid) begin
          fill_en    = 1'b1;
          next_state = RESPOND;
        end
      end
      WRITE_WAIT: begin
        if (mem_valid) begin
          next_state = RESPOND;
        end
      end
      RESPOND: begin
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      done  <= 1'b0;
      hit   <= 1'b0;
    end else begin
      state <= next_state;
      // done is high for the single RESPOND cycle
      done  <= (next_state == RESPOND);
      if (next_state == RESPOND) begin
        case (state)
          LOOKUP:     hit <= 1'b1;
          WRITE_WAIT: hit <= wr_hit_q;
          default:    hit <= 1'b0;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && enable) begin
      req_q <= req;
    end
    if (state == LOOKUP) begin
      wr_hit_q <= lookup_hit;
    end
    if (state == LOOKUP && !req_q.write && lookup_hit) begin
      rdata <= get_word(lookup_line, cur_sel);
    end else if (state == FILL_WAIT && mem_valid) begin
      rdata <= get_word(mem_rdata, cur_sel);
    end
  end

endmodule

// File: rtl/line_memory.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// backing memory of 512-bit lines, preloaded from the hex image;
// answers each request after MEM_LAT cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module line_memory import cache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     mem_req,
  input  mem_cmd_t mem_cmd,
  output line_t    mem_rdata,
  output logic     mem_valid
);

  line_t      mem [MEM_LINES];
  mem_cmd_t   cmd_q;
  logic       busy;
  lat_cnt_t   cnt;
  line_addr_t line_idx;
  word_sel_t  sel;

  initial begin
    $readmemh("sim/mem_init.hex", mem);
  end

  assign line_idx = addr_line(cmd_q.addr);
  assign sel      = addr_sel(cmd_q.addr);

  // request latched on the strobe edge, answered MEM_LAT cycles
  // after the strobe cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      cnt       <= '0;
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= 1'b0;
      if (mem_req && !busy) begin
        busy <= 1'b1;
        cnt  <= lat_cnt_t'(MEM_LAT - 1);
      end else if (busy) begin
        if (cnt == lat_cnt_t'(1)) begin
          busy      <= 1'b0;
          mem_valid <= 1'b1;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req && !busy) begin
      cmd_q <= mem_cmd;
    end
    if (busy && cnt == lat_cnt_t'(1)) begin
      if (cmd_q.write) begin
        mem[line_idx][sel*WORD_W +: WORD_W] <= cmd_q.wdata;
      end else begin
        mem_rdata <= mem[line_idx];
      end
    end
  end

endmodule

// File: rtl/cache_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache top level: controller, store and backing memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     enable,
  input  cpu_req_t req,
  output word_t    rdata,
  output logic     done,
  output logic     hit
);

  index_t    lookup_idx;
  tag_t      lookup_tag;
  logic      lookup_valid;
  line_t     lookup_line;
  logic      fill_en;
  index_t    fill_idx;
  tag_t      fill_tag;
  line_t     fill_line;
  logic      upd_en;
  index_t    upd_idx;
  word_sel_t upd_sel;
  word_t     upd_word;
  logic      mem_req;
  mem_cmd_t  mem_cmd;
  line_t     mem_rdata;
  logic      mem_valid;

  cache_ctrl cache_ctrl_inst (
    .clk          (clk),
    .rst          (rst),
    .enable       (enable),
    .req          (req),
    .rdata        (rdata),
    .done         (done),
    .hit          (hit),
    .lookup_idx   (lookup_idx),
    .lookup_tag   (lookup_tag),
    .lookup_valid (lookup_valid),
    .lookup_line  (lookup_line),
    .fill_en      (fill_en),
    .fill_idx     (fill_idx),
    .fill_tag     (fill_tag),
    .fill_line    (fill_line),
    .upd_en       (upd_en),
    .upd_idx      (upd_idx),
    .upd_sel      (upd_sel),
    .upd_word     (upd_word),
    .mem_req      (mem_req),
    .mem_cmd      (mem_cmd),
    .mem_rdata    (mem_rdata),
    .mem_valid    (mem_valid)
  );

  cache_store cache_store_inst (
    .clk          (clk),
    .rst          (rst),
    .lookup_idx   (lookup_idx),
    .lookup_tag   (lookup_tag),
    .lookup_valid (lookup_valid),
    .lookup_line  (lookup_line),
    .fill_en      (fill_en),
    .fill_idx     (fill_idx),
    .fill_tag     (fill_tag),
    .fill_line    (fill_line),
    .upd_en       (upd_en),
    .upd_idx      (upd_idx),
    .upd_sel      (upd_sel),
    .upd_word     (upd_word)
  );

  line_memory line_memory_inst (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_rdata (mem_rdata),
    .mem_valid (mem_valid)
  );

endmodule

// File: sim/cache_chk.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol assertions on the cache controller,
// bound into every cache_ctrl instance
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_chk import cache_pkg::*; (
  input logic        clk,
  input logic        rst,
  input ctrl_state_t state,
  input logic        mem_req,
  input logic        mem_valid,
  input logic        done
);

  // number of failed assertions
  int fail_count = 0;

  a_req_pulse: assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
    else begin
      fail_count++;
      $error("mem_req stayed high for two cycles");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      fail_count++;
      $error("done stayed high for two cycles");
    end

  // memory answers a fixed latency after the strobe
  a_mem_latency: assert property (@(posedge clk) disable iff (rst)
                                  $past(mem_req, MEM_LAT) |-> mem_valid)
    else begin
      fail_count++;
      $error("mem_valid missing MEM_LAT cycles after mem_req");
    end

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
                                 (state == IDLE) |-> !mem_req)
    else begin
      fail_count++;
      $error("mem_req issued in IDLE");
    end

endmodule

bind cache_ctrl cache_chk cache_chk_inst (
  .clk       (clk),
  .rst       (rst),
  .state     (state),
  .mem_req   (mem_req),
  .mem_valid (mem_valid),
  .done      (done)
);

// File: sim/cache_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for cache_top: directed and random accesses checked
// against a reference memory and tag model; top module cache_tb
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

  localparam int CLK_PERIOD        = 10;
  localparam int RESET_CYCLES      = 4;
  localparam int HIT_LATENCY       = 2;
  localparam int RANDOM_OPS        = 40;
  localparam int LINE_BYTES        = 64;
  localparam int WORD_BYTES        = 8;
  localparam int WORD_BITS         = 64;
  localparam int WORDS_PER_LINE    = 8;
  localparam int SLOTS             = 4;
  localparam int IMAGE_LINES       = 16;
  // about 60 accesses of at most 8 cycles each, with a wide margin
  localparam int MAX_ACCESSES      = 60;
  localparam int MAX_ACCESS_CYCLES = 8;
  localparam int TIMEOUT_CYCLES    = MAX_ACCESSES * MAX_ACCESS_CYCLES * 4 + 80;

  logic     clk;
  logic     rst;
  logic     enable;
  cpu_req_t req;
  word_t    rdata;
  logic     done;
  logic     hit;

  // reference memory image and cache tag model
  line_t  ref_mem   [IMAGE_LINES];
  logic   ref_valid [SLOTS];
  tag_t   ref_tag   [SLOTS];
  int     errors;
  int     cycles;
  integer seed;

  cache_top cache_top_inst (
    .clk    (clk),
    .rst    (rst),
    .enable (enable),
    .req    (req),
    .rdata  (rdata),
    .done   (done),
    .hit    (hit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // byte address split into line, slot, tag and lane numbers
  function automatic int line_of(addr_t a);
    return int'(a) / LINE_BYTES;
  endfunction

  function automatic int slot_of(addr_t a);
    return line_of(a) % SLOTS;
  endfunction

  function automatic tag_t tag_of(addr_t a);
    return tag_t'(line_of(a) / SLOTS);
  endfunction

  function automatic int lane_of(addr_t a);
    return (int'(a) / WORD_BYTES) % WORDS_PER_LINE;
  endfunction

  function automatic word_t ref_word(addr_t a);
    line_t l;
    l = ref_mem[line_of(a)];
    return l[lane_of(a)*WORD_BITS +: WORD_BITS];
  endfunction

  function automatic logic model_hit(addr_t a);
    return ref_valid[slot_of(a)] && (ref_tag[slot_of(a)] == tag_of(a));
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("ERR %s: data expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_hit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERR %s: hit expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("ERR %s: latency expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // starts and ends on a falling edge with the FSM in IDLE;
  // lat counts rising edges from the enable edge to done
  task automatic run_access(input cpu_req_t r, output word_t data, output logic h,
                            output int lat);
    enable = 1'b1;
    req    = r;
    @(posedge clk);
    lat = 1;
    @(negedge clk);
    enable = 1'b0;
    while (done !== 1'b1) begin
      @(posedge clk);
      lat = lat + 1;
      @(negedge clk);
    end
    data = rdata;
    h    = hit;
    // RESPOND back to IDLE
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic read_word(input string name, input addr_t a);
    cpu_req_t r;
    word_t    exp_data;
    logic     exp_hit;
    word_t    got_data;
    logic     got_hit;
    int       lat;
    exp_hit  = model_hit(a);
    exp_data = ref_word(a);
    r.write  = 1'b0;
    r.addr   = a;
    r.wdata  = '0;
    run_access(r, got_data, got_hit, lat);
    check_word(name, exp_data, got_data);
    check_hit(name, exp_hit, got_hit);
    if (exp_hit) begin
      check_latency(name, HIT_LATENCY, lat);
    end else begin
      // a read miss allocates the line
      ref_valid[slot_of(a)] = 1'b1;
      ref_tag[slot_of(a)]   = tag_of(a);
    end
  endtask

  task automatic write_word(input string name, input addr_t a, input word_t d);
    cpu_req_t r;
    logic     exp_hit;
    word_t    got_data;
    logic     got_hit;
    int       lat;
    exp_hit = model_hit(a);
    r.write = 1'b1;
    r.addr  = a;
    r.wdata = d;
    run_access(r, got_data, got_hit, lat);
    check_hit(name, exp_hit, got_hit);
    // write-through without allocation on a miss
    ref_mem[line_of(a)][lane_of(a)*WORD_BITS +: WORD_BITS] = d;
  endtask

  task automatic cold_read_miss();
    read_word("cold_miss", 10'h048);
  endtask

  task automatic same_line_read_hit();
    read_word("read_hit", 10'h070);
  endtask

  task automatic write_through_update();
    write_word("wt_write_hit", 10'h050, 64'h1111_2222_3333_4444);
    read_word("wt_read_hit", 10'h050);
    // same index, other tag
    read_word("wt_evict", 10'h150);
    read_word("wt_reread", 10'h050);
  endtask

  task automatic write_miss_no_allocate();
    write_word("na_write_miss", 10'h0c8, 64'hfeed_face_0bad_beef);
    read_word("na_read_miss", 10'h0c8);
  endtask

  task automatic alternating_conflict_reads();
    read_word("conflict_a0", 10'h088);
    read_word("conflict_b0", 10'h288);
    read_word("conflict_a1", 10'h088);
    read_word("conflict_b1", 10'h288);
  endtask

  task automatic random_access_mix();
    addr_t a;
    word_t d;
    logic  is_write;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      a        = addr_t'($random(seed));
      a[2:0]   = 3'b000;
      is_write = logic'($random(seed));
      d        = {$random(seed), $random(seed)};
      if (is_write) begin
        write_word($sformatf("random_wr_%0d", i), a, d);
      end else begin
        read_word($sformatf("random_rd_%0d", i), a);
      end
    end
  endtask

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int chk_fails;
    rst    = 1'b1;
    enable = 1'b0;
    req    = '0;
    errors = 0;
    seed   = 32'hb483_b574;
    for (int s = 0; s < SLOTS; s++) begin
      ref_valid[s] = 1'b0;
      ref_tag[s]   = '0;
    end
    $readmemh("sim/mem_init.hex", ref_mem);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    cold_read_miss();
    same_line_read_hit();
    write_through_update();
    write_miss_no_allocate();
    alternating_conflict_reads();
    random_access_mix();

    chk_fails = cache_top_inst.cache_ctrl_inst.cache_chk_inst.fail_count;
    $display("errors: %0d compare, %0d assertion", errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: sim/mem_init.hex
// one 512-bit line per row, line 0 first; word 7 leftmost, word 0 rightmost
// each word is its line and word number repeated, line 3 word 5 = 3535353535353535
07070707070707070606060606060606050505050505050504040404040404040303030303030303020202020202020201010101010101010000000000000000
17171717171717171616161616161616151515151515151514141414141414141313131313131313121212121212121211111111111111111010101010101010
27272727272727272626262626262626252525252525252524242424242424242323232323232323222222222222222221212121212121212020202020202020
37373737373737373636363636363636353535353535353534343434343434343333333333333333323232323232323231313131313131313030303030303030
47474747474747474646464646464646454545454545454544444444444444444343434343434343424242424242424241414141414141414040404040404040
57575757575757575656565656565656555555555555555554545454545454545353535353535353525252525252525251515151515151515050505050505050
67676767676767676666666666666666656565656565656564646464646464646363636363636363626262626262626261616161616161616060606060606060
77777777777777777676767676767676757575757575757574747474747474747373737373737373727272727272727271717171717171717070707070707070
87878787878787878686868686868686858585858585858584848484848484848383838383838383828282828282828281818181818181818080808080808080
97979797979797979696969696969696959595959595959594949494949494949393939393939393929292929292929291919191919191919090909090909090
a7a7a7a7a7a7a7a7a6a6a6a6a6a6a6a6a5a5a5a5a5a5a5a5a4a4a4a4a4a4a4a4a3a3a3a3a3a3a3a3a2a2a2a2a2a2a2a2a1a1a1a1a1a1a1a1a0a0a0a0a0a0a0a0
b7b7b7b7b7b7b7b7b6b6b6b6b6b6b6b6b5b5b5b5b5b5b5b5b4b4b4b4b4b4b4b4b3b3b3b3b3b3b3b3b2b2b2b2b2b2b2b2b1b1b1b1b1b1b1b1b0b0b0b0b0b0b0b0
c7c7c7c7c7c7c7c7c6c6c6c6c6c6c6c6c5c5c5c5c5c5c5c5c4c4c4c4c4c4c4c4c3c3c3c3c3c3c3c3c2c2c2c2c2c2c2c2c1c1c1c1c1c1c1c1c0c0c0c0c0c0c0c0
d7d7d7d7d7d7d7d7d6d6d6d6d6d6d6d6d5d5d5d5d5d5d5d5d4d4d4d4d4d4d4d4d3d3d3d3d3d3d3d3d2d2d2d2d2d2d2d2d1d1d1d1d1d1d1d1d0d0d0d0d0d0d0d0
e7e7e7e7e7e7e7e7e6e6e6e6e6e6e6e6e5e5e5e5e5e5e5e5e4e4e4e4e4e4e4e4e3e3e3e3e3e3e3e3e2e2e2e2e2e2e2e2e1e1e1e1e1e1e1e1e0e0e0e0e0e0e0e0
f7f7f7f7f7f7f7f7f6f6f6f6f6f6f6f6f5f5f5f5f5f5f5f5f4f4f4f4f4f4f4f4f3f3f3f3f3f3f3f3f2f2f2f2f2f2f2f2f1f1f1f1f1f1f1f1f0f0f0f0f0f0f0f0

// File: filelist.f
rtl/cache_pkg.sv
rtl/cache_store.sv
rtl/cache_ctrl.sv
rtl/line_memory.sv
rtl/cache_top.sv
sim/cache_chk.sv
sim/cache_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := cache_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS   := +verilator+error+limit+100
PASS_MSG   := SIMULATION PASSED

.PHONY: lint sim build clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# run from the project root so the memory image path resolves
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
